/* src/noc_pkg.sv */
// ------------------------------
// Shared widths and encodings of the mesh router
// Flit fields are bit positions over a plain vector
// Coordinates are unsigned, four bits per axis
// ------------------------------

package noc_pkg;

  // Router radix: local port plus four mesh neighbours
  localparam int unsigned NumPorts = 5;

  // One mesh coordinate
  localparam int unsigned CoordW = 4;
  typedef logic [CoordW-1:0] coord_t;

  // Flit layout, from bit 0 upward:
  //   payload, destination X, destination Y, last flag
  localparam int unsigned PayloadW = 15;
  localparam int unsigned DstXLsb  = PayloadW;
  localparam int unsigned DstYLsb  = DstXLsb + CoordW;
  localparam int unsigned LastBit  = DstYLsb + CoordW;
  localparam int unsigned FlitW    = LastBit + 1;

  typedef logic [FlitW-1:0] flit_t;

  // One bit per port, used for routes, requests and grants
  typedef logic [NumPorts-1:0] port_sel_t;

  // Port numbering of the router
  typedef enum logic [2:0] {
    Eject = 3'd0,
    South = 3'd1,
    West  = 3'd2,
    North = 3'd3,
    East  = 3'd4
  } port_e;

  // Entries per input buffer
  localparam int unsigned FifoDepth = 2;

endpackage

/* src/noc_flit_fifo.sv */
// ------------------------------
// Input flit buffer, FifoDepth entries
// A write shows on the read side one cycle later
// Accepts a write while full if the head leaves
// ------------------------------
`timescale 1ns/1ns

module noc_flit_fifo
  import noc_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  flit_t wr_flit_i,
  input  logic  wr_valid_i,
  output logic  wr_ready_o,
  output flit_t rd_flit_o,
  output logic  rd_valid_o,
  input  logic  rd_ready_i
);

  localparam int unsigned PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  typedef logic [PtrW-1:0] ptr_t;

  flit_t           mem_q [FifoDepth];
  ptr_t            wr_ptr_q;
  ptr_t            rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;

  function automatic ptr_t next_ptr(input ptr_t ptr);
    ptr_t nxt;
    nxt = ptr + ptr_t'(1);
    if (ptr == ptr_t'(FifoDepth - 1)) begin
      nxt = '0;
    end
    return nxt;
  endfunction

  assign rd_valid_o = (count_q != '0);
  assign rd_flit_o  = mem_q[rd_ptr_q];
  // Full buffer still takes a flit when the head drains this cycle
  assign wr_ready_o = (count_q != CntW'(FifoDepth)) || rd_ready_i;

  assign push = wr_valid_i && wr_ready_o;
  assign pop  = rd_valid_o && rd_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wr_flit_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + CntW'(1);
      end else if (pop && !push) begin
        count_q <= count_q - CntW'(1);
      end
    end
  end

  a_count_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    count_q <= CntW'(FifoDepth)
  ) else $error("FIFO count above depth");

endmodule

/* src/noc_route_select.sv */
// ------------------------------
// XY route decision for one input port
// Route comes from the head flit, then stays
// locked until the tail flit has been sent
// ------------------------------
`timescale 1ns/1ns

module noc_route_select
  import noc_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  coord_t    pos_x_i,
  input  coord_t    pos_y_i,
  input  flit_t     flit_i,
  input  logic      valid_i,
  input  logic      ready_i,
  output port_sel_t route_sel_o
);

  coord_t    dst_x;
  coord_t    dst_y;
  port_e     route_dir;
  port_sel_t route_sel;
  logic      locked_q;
  port_sel_t route_q;

  assign dst_x = coord_t'(flit_i[DstXLsb +: CoordW]);
  assign dst_y = coord_t'(flit_i[DstYLsb +: CoordW]);

  // X is resolved first, Y only once the column matches
  always_comb begin : proc_xy_route
    route_dir = East;
    if (dst_x == pos_x_i && dst_y == pos_y_i) begin
      route_dir = Eject;
    end else if (dst_x == pos_x_i) begin
      if (dst_y < pos_y_i) begin
        route_dir = South;
      end else begin
        route_dir = North;
      end
    end else begin
      if (dst_x < pos_x_i) begin
        route_dir = West;
      end else begin
        route_dir = East;
      end
    end
    route_sel = '0;
    route_sel[route_dir] = 1'b1;
  end

  // Lock follows the last flag of every flit that leaves
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      locked_q <= 1'b0;
      route_q  <= '0;
    end else begin
      if (valid_i && ready_i) begin
        locked_q <= ~flit_i[LastBit];
      end
      // Route of the head is captured while the port is free
      if (!locked_q) begin
        route_q <= route_sel;
      end
    end
  end

  // Body flits reuse the head's route, whatever their header bits say
  assign route_sel_o = locked_q ? route_q : route_sel;

  a_route_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_i |-> $onehot(route_sel_o)
  ) else $error("Route select is not one-hot");

endmodule

/* src/noc_output_arbiter.sv */
// ------------------------------
// Round-robin arbiter of one output port
// Grant is kept from the first flit to the tail
// and while the output is stalled
// ------------------------------
`timescale 1ns/1ns

module noc_output_arbiter
  import noc_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  port_sel_t req_i,
  input  logic      flit_last_i,
  input  logic      out_ready_i,
  output port_sel_t grant_o
);

  logic      lock_q;
  port_sel_t grant_q;
  port_e     ptr_q;
  port_sel_t arb_grant;
  port_e     winner;
  logic      out_valid;
  logic      xfer;

  // Search starts at the input right after the last winner
  always_comb begin : proc_rr_pick
    int unsigned idx;
    logic        found;
    arb_grant = '0;
    found     = 1'b0;
    for (int unsigned i = 1; i <= NumPorts; i++) begin
      idx = (int'(ptr_q) + i) % NumPorts;
      if (!found && req_i[idx]) begin
        arb_grant[idx] = 1'b1;
        found          = 1'b1;
      end
    end
  end

  assign grant_o = lock_q ? grant_q : arb_grant;

  always_comb begin : proc_winner
    winner = ptr_q;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      if (grant_o[i]) begin
        winner = port_e'(i);
      end
    end
  end

  assign out_valid = |(grant_o & req_i);
  assign xfer      = out_valid && out_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q  <= 1'b0;
      grant_q <= '0;
      // Points at the highest port so that Eject is looked at first
      ptr_q   <= East;
    end else begin
      if (xfer && flit_last_i) begin
        lock_q <= 1'b0;
      end else if (out_valid) begin
        lock_q <= 1'b1;
      end
      if (!lock_q && out_valid) begin
        grant_q <= arb_grant;
        ptr_q   <= winner;
      end
    end
  end

  a_grant_onehot0: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(grant_o)
  ) else $error("Arbiter grant is not one-hot");

  // No other input may take the port before the tail has left
  a_grant_held: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (out_valid && !(out_ready_i && flit_last_i)) |=> (grant_o == $past(grant_o))
  ) else $error("Arbiter grant changed inside a packet");

endmodule

/* src/noc_router.sv */
// ------------------------------
// Five-port wormhole router, XY routing
// One cycle from input accept to output valid
// No virtual channels, valid/ready on all links
// ------------------------------
`timescale 1ns/1ns

module noc_router
  import noc_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  coord_t                pos_x_i,
  input  coord_t                pos_y_i,
  input  flit_t [NumPorts-1:0]  in_flit_i,
  input  logic  [NumPorts-1:0]  in_valid_i,
  output logic  [NumPorts-1:0]  in_ready_o,
  output flit_t [NumPorts-1:0]  out_flit_o,
  output logic  [NumPorts-1:0]  out_valid_o,
  input  logic  [NumPorts-1:0]  out_ready_i
);

  flit_t [NumPorts-1:0] head_flit;
  logic  [NumPorts-1:0] head_valid;
  logic  [NumPorts-1:0] head_ready;
  logic  [NumPorts-1:0] out_last;

  // Indexed by input port
  port_sel_t route_sel [NumPorts];
  // Indexed by output port, one bit per input
  port_sel_t req       [NumPorts];
  port_sel_t grant     [NumPorts];

  for (genvar p = 0; p < NumPorts; p++) begin : gen_input
    noc_flit_fifo i_fifo (
      .clk_i      ( clk_i         ),
      .rst_n_i    ( rst_n_i       ),
      .wr_flit_i  ( in_flit_i[p]  ),
      .wr_valid_i ( in_valid_i[p] ),
      .wr_ready_o ( in_ready_o[p] ),
      .rd_flit_o  ( head_flit[p]  ),
      .rd_valid_o ( head_valid[p] ),
      .rd_ready_i ( head_ready[p] )
    );

    noc_route_select i_route (
      .clk_i       ( clk_i         ),
      .rst_n_i     ( rst_n_i       ),
      .pos_x_i     ( pos_x_i       ),
      .pos_y_i     ( pos_y_i       ),
      .flit_i      ( head_flit[p]  ),
      .valid_i     ( head_valid[p] ),
      .ready_i     ( head_ready[p] ),
      .route_sel_o ( route_sel[p]  )
    );
  end

  // Transpose routes into per-output request vectors
  always_comb begin : proc_req
    for (int o = 0; o < NumPorts; o++) begin
      for (int p = 0; p < NumPorts; p++) begin
        req[o][p] = head_valid[p] && route_sel[p][o];
      end
    end
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_output
    noc_output_arbiter i_arb (
      .clk_i       ( clk_i          ),
      .rst_n_i     ( rst_n_i        ),
      .req_i       ( req[o]         ),
      .flit_last_i ( out_last[o]    ),
      .out_ready_i ( out_ready_i[o] ),
      .grant_o     ( grant[o]       )
    );
  end

  // Grant-driven output multiplexers
  always_comb begin : proc_out_mux
    for (int o = 0; o < NumPorts; o++) begin
      out_flit_o[o]  = '0;
      out_valid_o[o] = 1'b0;
      for (int p = 0; p < NumPorts; p++) begin
        if (grant[o][p]) begin
          out_flit_o[o]  = head_flit[p];
          out_valid_o[o] = head_valid[p];
        end
      end
      out_last[o] = out_flit_o[o][LastBit];
    end
  end

  // An input pops when the output holding its grant is ready
  always_comb begin : proc_head_ready
    for (int p = 0; p < NumPorts; p++) begin
      head_ready[p] = 1'b0;
      for (int o = 0; o < NumPorts; o++) begin
        head_ready[p] = head_ready[p] | (grant[o][p] & out_ready_i[o]);
      end
    end
  end

  // Route lock and arbiter locks together keep an input on one output
  for (genvar p = 0; p < NumPorts; p++) begin : gen_chk
    port_sel_t owner;

    always_comb begin
      for (int o = 0; o < NumPorts; o++) begin
        owner[o] = grant[o][p];
      end
    end

    a_single_owner: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      head_valid[p] |-> $onehot0(owner)
    ) else $error("Input granted by more than one output");
  end

endmodule

/* test/tb_noc_router.sv */
// ------------------------------
// Directed tests of the five-port router at X 2, Y 2
// Payload carries source port and sequence number
// Expected outputs follow the XY rule
// ------------------------------
`timescale 1ns/1ns

module tb_noc_router import noc_pkg::*; ();

  localparam coord_t PosX   = 4'd2;
  localparam coord_t PosY   = 4'd2;
  localparam int     SrcLsb = 12;

  logic                 clk;
  logic                 rst_n;
  flit_t [NumPorts-1:0] in_flit;
  logic  [NumPorts-1:0] in_valid;
  logic  [NumPorts-1:0] in_ready;
  flit_t [NumPorts-1:0] out_flit;
  logic  [NumPorts-1:0] out_valid;
  logic  [NumPorts-1:0] out_ready;

  // Pending stimulus per input, with the output each flit must use
  flit_t send_q   [NumPorts][$];
  int    send_out [NumPorts][$];
  // Scoreboard, indexed by output * NumPorts + source
  flit_t exp_flit [NumPorts*NumPorts][$];
  int    exp_cyc  [NumPorts*NumPorts][$];

  logic [11:0]         seq_cnt [NumPorts];
  int                  accept_cnt [NumPorts];
  logic [NumPorts-1:0] pkt_open;
  int                  pkt_src [NumPorts];
  logic [NumPorts-1:0] stall_mask;
  logic                rand_ready;
  logic                check_latency;
  int                  cyc;
  int                  value_errors;
  int                  other_errors;
  integer              seed;
  string               test_name;

  noc_router dut (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .pos_x_i     ( PosX      ),
    .pos_y_i     ( PosY      ),
    .in_flit_i   ( in_flit   ),
    .in_valid_i  ( in_valid  ),
    .in_ready_o  ( in_ready  ),
    .out_flit_o  ( out_flit  ),
    .out_valid_o ( out_valid ),
    .out_ready_i ( out_ready )
  );

  always #4 clk = ~clk;

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      value_errors++;
      $display("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
               test_name, what, expected, actual);
    end
  endtask

  task automatic report_failure(input string msg);
    other_errors++;
    $display("Failure in test %s: %s", test_name, msg);
  endtask

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  // Dimension-ordered routing, X first
  function automatic int xy_port(input coord_t dx, input coord_t dy);
    if (dx == PosX && dy == PosY) begin
      return int'(Eject);
    end
    if (dx == PosX) begin
      return (dy < PosY) ? int'(South) : int'(North);
    end
    return (dx < PosX) ? int'(West) : int'(East);
  endfunction

  task automatic queue_packet(input int src, input int len, input coord_t dx,
                              input coord_t dy, input int out);
    flit_t  f;
    coord_t bx;
    // Body flits name a column on the other side, so only the lock keeps them on route
    bx = (dx < PosX) ? PosX + 4'd1 : PosX - 4'd1;
    for (int i = 0; i < len; i++) begin
      f = '0;
      f[LastBit] = (i == len - 1);
      f[DstXLsb +: CoordW] = (i == 0) ? dx : bx;
      f[DstYLsb +: CoordW] = dy;
      f[SrcLsb +: 3] = src[2:0];
      f[SrcLsb-1:0] = seq_cnt[src];
      seq_cnt[src] = seq_cnt[src] + 12'd1;
      send_q[src].push_back(f);
      send_out[src].push_back(out);
    end
  endtask

  task automatic record_accept(input int p);
    int key;
    key = send_out[p][0] * NumPorts + p;
    exp_flit[key].push_back(send_q[p][0]);
    exp_cyc[key].push_back(cyc);
    void'(send_q[p].pop_front());
    void'(send_out[p].pop_front());
    accept_cnt[p]++;
  endtask

  task automatic check_output(input int o, input flit_t f);
    int src;
    int key;
    src = int'(f[SrcLsb +: 3]);
    if (src >= NumPorts) begin
      report_failure($sformatf("output %0d sent a flit with unknown source %0d", o, src));
    end else begin
      key = o * NumPorts + src;
      if (exp_flit[key].size() == 0) begin
        report_failure($sformatf("output %0d sent a flit from input %0d that was not routed there",
                                 o, src));
      end else begin
        check_value($sformatf("flit on output %0d from input %0d", o, src),
                    exp_flit[key][0], f);
        if (check_latency) begin
          check_value("latency in cycles", 1, cyc - exp_cyc[key][0]);
        end
        void'(exp_flit[key].pop_front());
        void'(exp_cyc[key].pop_front());
      end
      if (pkt_open[o] && pkt_src[o] != src) begin
        report_failure($sformatf("packets from inputs %0d and %0d interleaved on output %0d",
                                 pkt_src[o], src, o));
      end
      pkt_open[o] = !f[LastBit];
      pkt_src[o]  = src;
    end
  endtask

  // Samples handshakes at the edge, then drives new values 1 ns later
  always begin : drive_and_monitor
    @(posedge clk);
    cyc++;
    if (rst_n) begin
      for (int o = 0; o < NumPorts; o++) begin
        if (out_valid[o] && out_ready[o]) begin
          check_output(o, out_flit[o]);
        end
      end
      for (int p = 0; p < NumPorts; p++) begin
        if (in_valid[p] && in_ready[p]) begin
          record_accept(p);
        end
      end
    end
    #1;
    for (int p = 0; p < NumPorts; p++) begin
      if (send_q[p].size() != 0) begin
        in_flit[p]  = send_q[p][0];
        in_valid[p] = 1'b1;
      end else begin
        in_flit[p]  = '0;
        in_valid[p] = 1'b0;
      end
    end
    for (int o = 0; o < NumPorts; o++) begin
      if (stall_mask[o]) begin
        out_ready[o] = 1'b0;
      end else if (rand_ready) begin
        out_ready[o] = (rand_below(2) != 0);
      end else begin
        out_ready[o] = 1'b1;
      end
    end
  end

  function automatic logic traffic_idle();
    logic idle;
    idle = (in_valid == '0);
    for (int i = 0; i < NumPorts; i++) begin
      idle = idle && (send_q[i].size() == 0);
    end
    for (int k = 0; k < NumPorts * NumPorts; k++) begin
      idle = idle && (exp_flit[k].size() == 0);
    end
    return idle;
  endfunction

  task automatic flush_queues();
    for (int i = 0; i < NumPorts; i++) begin
      send_q[i].delete();
      send_out[i].delete();
    end
    for (int k = 0; k < NumPorts * NumPorts; k++) begin
      exp_flit[k].delete();
      exp_cyc[k].delete();
    end
    pkt_open = '0;
  endtask

  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    while (!traffic_idle() && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!traffic_idle()) begin
      report_failure($sformatf("traffic did not drain within %0d cycles", limit));
      flush_queues();
    end
  endtask

  task automatic test_reset_state();
    test_name = "reset_state";
    check_value("out_valid after reset", 0, out_valid);
    check_value("in_ready after reset", 5'h1f, in_ready);
  endtask

  task automatic test_single_flit();
    test_name = "single_flit";
    check_latency = 1'b1;
    queue_packet(Eject, 1, 4'd2, 4'd2, Eject);
    wait_idle(20);
    queue_packet(South, 1, 4'd2, 4'd0, South);
    wait_idle(20);
    queue_packet(West, 1, 4'd0, 4'd2, West);
    wait_idle(20);
    queue_packet(North, 1, 4'd2, 4'd5, North);
    wait_idle(20);
    queue_packet(East, 1, 4'd5, 4'd2, East);
    wait_idle(20);
    check_latency = 1'b0;
  endtask

  task automatic test_wormhole_body();
    test_name = "wormhole_body";
    queue_packet(West, 4, 4'd4, 4'd1, xy_port(4'd4, 4'd1));
    wait_idle(40);
  endtask

  task automatic test_eject_contention();
    test_name = "eject_contention";
    queue_packet(North, 3, PosX, PosY, xy_port(PosX, PosY));
    queue_packet(South, 3, PosX, PosY, xy_port(PosX, PosY));
    queue_packet(North, 2, PosX, PosY, xy_port(PosX, PosY));
    queue_packet(South, 4, PosX, PosY, xy_port(PosX, PosY));
    wait_idle(80);
  endtask

  task automatic test_backpressure();
    int    base;
    int    n;
    flit_t held;
    test_name = "backpressure";
    stall_mask[East] = 1'b1;
    base = accept_cnt[West];
    queue_packet(West, 4, 4'd5, PosY, East);
    n = 0;
    while (in_ready[West] && n < 50) begin
      @(negedge clk);
      n++;
    end
    if (in_ready[West]) begin
      report_failure("West input stayed ready while East was stalled");
    end
    check_value("flits accepted before stall", FifoDepth, accept_cnt[West] - base);
    check_value("stalled East valid", 1, out_valid[East]);
    held = out_flit[East];
    repeat (4) begin
      @(negedge clk);
      check_value("stalled East flit", held, out_flit[East]);
      check_value("West ready while stalled", 0, in_ready[West]);
    end
    stall_mask[East] = 1'b0;
    wait_idle(60);
  endtask

  task automatic test_random_traffic();
    int     src;
    int     len;
    coord_t dx;
    coord_t dy;
    test_name = "random_traffic";
    rand_ready = 1'b1;
    for (int k = 0; k < 60; k++) begin
      src = rand_below(NumPorts);
      len = 1 + rand_below(4);
      dx  = coord_t'(rand_below(6));
      dy  = coord_t'(rand_below(6));
      queue_packet(src, len, dx, dy, xy_port(dx, dy));
    end
    wait_idle(4000);
    rand_ready = 1'b0;
  endtask

  initial begin
    seed          = 10015;
    clk           = 1'b0;
    rst_n         = 1'b0;
    in_flit       = '0;
    in_valid      = '0;
    out_ready     = '1;
    stall_mask    = '0;
    rand_ready    = 1'b0;
    check_latency = 1'b0;
    pkt_open      = '0;
    cyc           = 0;
    value_errors  = 0;
    other_errors  = 0;
    test_name     = "init";
    for (int i = 0; i < NumPorts; i++) begin
      seq_cnt[i]    = '0;
      accept_cnt[i] = 0;
      pkt_src[i]    = 0;
    end
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);

    test_reset_state();
    test_single_flit();
    test_wormhole_body();
    test_eject_contention();
    test_backpressure();
    test_random_traffic();

    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
src/noc_pkg.sv
src/noc_flit_fifo.sv
src/noc_route_select.sv
src/noc_output_arbiter.sv
src/noc_router.sv
test/tb_noc_router.sv

/* run_sim.sh */
#!/bin/sh
# Builds the router testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_noc_router -f tb.f \
  --Mdir obj_dir -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Result: PASSED" sim.log; then
  echo "Simulation passed (exit status $status)"
else
  echo "Simulation did not pass (exit status $status)"
  exit 1
fi
